// ==== source/sd_test_pkg.sv ====
package sd_test_pkg;

  // ==================================================
  // constants
  // ==================================================
  localparam int SPI_HALF_PERIOD = 2;       // clocks per sclk half-period.
  localparam int TEST_BLOCKS     = 4;
  localparam int R1_POLL_LIMIT   = 16;      // bytes.
  localparam int BUSY_POLL_LIMIT = 4096;    // bytes.

  localparam logic [5:0] CMD_READ_BLOCK  = 6'd17;
  localparam logic [5:0] CMD_WRITE_BLOCK = 6'd24;
  localparam logic [7:0] TOKEN_START     = 8'hFE;

  // tester state codes, block address rides in bits 11:8.
  localparam logic [15:0] TEST_START = 16'h0000;
  localparam logic [15:0] TEST_WRITE = 16'h0001;
  localparam logic [15:0] TEST_READ  = 16'h0002;
  localparam logic [15:0] TEST_END   = 16'hFFFF;
  localparam logic [15:0] READ_ERROR = 16'hFFFE;
  localparam logic [15:0] LINK_FAULT = 16'hFFFD;

  // tester steps within a phase.
  localparam logic [1:0] STEP_ISSUE = 2'd0;
  localparam logic [1:0] STEP_WAIT  = 2'd1;
  localparam logic [1:0] STEP_CHECK = 2'd2;
  localparam logic [1:0] STEP_GAP   = 2'd3;

  // block controller FSM.
  localparam logic [3:0] CTRL_IDLE     = 4'd0;
  localparam logic [3:0] CTRL_CMD      = 4'd1;
  localparam logic [3:0] CTRL_R1       = 4'd2;
  localparam logic [3:0] CTRL_WR_TOKEN = 4'd3;
  localparam logic [3:0] CTRL_WR_DATA  = 4'd4;
  localparam logic [3:0] CTRL_WR_CRC   = 4'd5;
  localparam logic [3:0] CTRL_WR_RESP  = 4'd6;
  localparam logic [3:0] CTRL_WR_BUSY  = 4'd7;
  localparam logic [3:0] CTRL_RD_TOKEN = 4'd8;
  localparam logic [3:0] CTRL_RD_DATA  = 4'd9;
  localparam logic [3:0] CTRL_RD_CRC   = 4'd10;
  localparam logic [3:0] CTRL_FINISH   = 4'd11;

  // ==================================================
  // types
  // ==================================================
  typedef logic [4095:0] block_t;
  typedef logic [31:0]   block_addr_t;
  typedef logic [15:0]   tester_state_t;

  typedef struct packed {
    logic        read;
    logic        write;
    block_addr_t addr;
    block_t      data;
  } sd_request_t;

  typedef struct packed {
    logic   busy;
    logic   fault;
    block_t data;
  } sd_response_t;

  typedef struct packed {
    logic [7:0]  head;       // start bits and index.
    logic [31:0] argument;
    logic [7:0]  tail;       // crc and stop bit.
  } sd_command_fields_t;

  // bytes[0] goes out first.
  typedef union packed {
    sd_command_fields_t   fields;
    logic [0:5][7:0]      bytes;
  } sd_command_u;

  // byte k of block a is (a*16 + k) xor A5.
  function automatic block_t block_pattern(input block_addr_t addr);
    block_t      blk;
    logic [31:0] value;
    for (int k = 0; k < 512; k++) begin
      value = addr * 32'd16 + 32'(k);
      blk[8*k +: 8] = value[7:0] ^ 8'hA5;
    end
    return blk;
  endfunction

endpackage

// ==== source/spi_byte_shifter.sv ====
`timescale 1ns/1ps

module spi_byte_shifter import sd_test_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       start,
  input  logic [7:0] tx_byte,
  input  logic       miso,
  output logic       done,
  output logic [7:0] rx_byte,
  output logic       sclk,
  output logic       mosi
);

  logic       active;
  logic [7:0] div_count;
  logic [3:0] half_count;
  logic [7:0] shift_out;
  logic [7:0] shift_in;
  logic       edge_tick;

  assign edge_tick = active && (div_count == 8'(SPI_HALF_PERIOD - 1));
  assign mosi      = active ? shift_out[7] : 1'b1;  // idle high.

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      active     <= 1'b0;
      div_count  <= '0;
      half_count <= '0;
      sclk       <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!active) begin
        if (start) begin
          active     <= 1'b1;
          div_count  <= '0;
          half_count <= '0;
        end
      end else if (edge_tick) begin
        div_count  <= '0;
        sclk       <= ~sclk;
        half_count <= half_count + 4'd1;
        if (half_count == 4'd15) begin  // eighth falling edge.
          active <= 1'b0;
          done   <= 1'b1;
        end
      end else begin
        div_count <= div_count + 8'd1;
      end
    end
  end

  // shift data, even half-periods end on a rising edge.
  always_ff @(posedge clock) begin
    if (start && !active) begin
      shift_out <= tx_byte;
    end else if (edge_tick) begin
      if (half_count[0]) begin
        shift_out <= {shift_out[6:0], 1'b1};
      end else begin
        shift_in <= {shift_in[6:0], miso};
      end
      if (half_count == 4'd15) begin
        rx_byte <= shift_in;
      end
    end
  end

endmodule

// ==== source/sd_block_controller.sv ====
`timescale 1ns/1ps

module sd_block_controller import sd_test_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  sd_request_t  request,
  input  logic         miso,
  output sd_response_t response,
  output logic         sclk,
  output logic         mosi,
  output logic         cs_n
);

  logic [3:0]  phase;
  logic        busy;
  logic        fault;
  logic        in_flight;
  logic        req_write;
  logic [9:0]  byte_count;
  logic [12:0] poll_count;
  block_addr_t req_addr;
  block_t      req_data;
  block_t      rd_data;
  sd_command_u cmd;

  logic        start;
  logic        done;
  logic [7:0]  tx_byte;
  logic [7:0]  rx_byte;
  logic        shift_sclk;

  logic        is_poll;
  logic        reply_bad;
  logic        fail;
  logic [7:0]  idle_byte;
  logic [9:0]  last_index;
  logic [12:0] poll_max;

  spi_byte_shifter u_shifter (
    .clock   (clock),
    .reset   (reset),
    .start   (start),
    .tx_byte (tx_byte),
    .miso    (miso),
    .done    (done),
    .rx_byte (rx_byte),
    .sclk    (shift_sclk),
    .mosi    (mosi)
  );

  assign sclk     = shift_sclk & ~cs_n;  // no clock to a deselected card.
  assign start    = (phase != CTRL_IDLE) && !in_flight;
  assign response = '{busy: busy, fault: fault, data: rd_data};

  // ==================================================
  // command frame and byte select
  // ==================================================
  always_comb begin
    cmd.fields.head     = {2'b01, req_write ? CMD_WRITE_BLOCK : CMD_READ_BLOCK};
    cmd.fields.argument = req_addr;
    cmd.fields.tail     = 8'h01;  // dummy crc, stop bit.
    case (phase)
      CTRL_CMD:      tx_byte = cmd.bytes[byte_count[2:0]];
      CTRL_WR_TOKEN: tx_byte = TOKEN_START;
      CTRL_WR_DATA:  tx_byte = req_data[{byte_count[8:0], 3'b000} +: 8];
      default:       tx_byte = 8'hFF;
    endcase
  end

  // polling and reply checks on the received byte.
  always_comb begin
    is_poll   = phase inside {CTRL_R1, CTRL_WR_RESP, CTRL_WR_BUSY, CTRL_RD_TOKEN};
    idle_byte = (phase == CTRL_WR_BUSY) ? 8'h00 : 8'hFF;
    poll_max  = 13'(BUSY_POLL_LIMIT - 1);
    if (phase == CTRL_R1 || phase == CTRL_WR_RESP) begin
      poll_max = 13'(R1_POLL_LIMIT - 1);
    end
    case (phase)
      CTRL_R1:       reply_bad = (rx_byte != 8'h00);
      CTRL_WR_RESP:  reply_bad = (rx_byte[4:0] != 5'b00101);  // accepted only.
      CTRL_RD_TOKEN: reply_bad = (rx_byte != TOKEN_START);
      default:       reply_bad = 1'b0;
    endcase
    fail = is_poll && ((rx_byte == idle_byte) ? (poll_count == poll_max) : reply_bad);
    case (phase)
      CTRL_CMD:                   last_index = 10'd5;
      CTRL_WR_DATA, CTRL_RD_DATA: last_index = 10'd511;
      CTRL_WR_CRC, CTRL_RD_CRC:   last_index = 10'd1;
      default:                    last_index = 10'd0;
    endcase
  end

  // ==================================================
  // phase sequencing
  // ==================================================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      phase      <= CTRL_IDLE;
      busy       <= 1'b0;
      fault      <= 1'b0;
      in_flight  <= 1'b0;
      req_write  <= 1'b0;
      cs_n       <= 1'b1;
      byte_count <= '0;
      poll_count <= '0;
    end else begin
      if (start) begin
        in_flight <= 1'b1;
      end
      if (phase == CTRL_IDLE) begin
        if (request.read || request.write) begin
          busy       <= 1'b1;
          fault      <= 1'b0;
          req_write  <= request.write;
          cs_n       <= 1'b0;
          byte_count <= '0;
          poll_count <= '0;
          phase      <= CTRL_CMD;
        end
      end else if (done) begin
        in_flight  <= 1'b0;
        byte_count <= byte_count + 10'd1;
        if (fail) begin
          fault      <= 1'b1;
          cs_n       <= 1'b1;
          byte_count <= '0;
          phase      <= CTRL_FINISH;
        end else if (is_poll && rx_byte == idle_byte) begin
          poll_count <= poll_count + 13'd1;
        end else if (is_poll || byte_count == last_index) begin
          byte_count <= '0;
          poll_count <= '0;
          case (phase)
            CTRL_CMD:      phase <= CTRL_R1;
            CTRL_R1:       phase <= req_write ? CTRL_WR_TOKEN : CTRL_RD_TOKEN;
            CTRL_WR_TOKEN: phase <= CTRL_WR_DATA;
            CTRL_WR_DATA:  phase <= CTRL_WR_CRC;
            CTRL_WR_CRC:   phase <= CTRL_WR_RESP;
            CTRL_WR_RESP:  phase <= CTRL_WR_BUSY;
            CTRL_RD_TOKEN: phase <= CTRL_RD_DATA;
            CTRL_RD_DATA:  phase <= CTRL_RD_CRC;
            CTRL_WR_BUSY, CTRL_RD_CRC: begin
              cs_n  <= 1'b1;
              phase <= CTRL_FINISH;  // one trailing byte.
            end
            default: begin
              busy  <= 1'b0;
              phase <= CTRL_IDLE;
            end
          endcase
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (phase == CTRL_IDLE && (request.read || request.write)) begin
      req_addr <= request.addr;
      req_data <= request.data;
    end
    if (done && phase == CTRL_RD_DATA) begin
      rd_data[{byte_count[8:0], 3'b000} +: 8] <= rx_byte;
    end
  end

endmodule

// ==== source/sd_block_tester.sv ====
`timescale 1ns/1ps

module sd_block_tester import sd_test_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  sd_response_t  response,
  output sd_request_t   request,
  output tester_state_t test_state
);

  tester_state_t state;
  logic [1:0]    step;
  logic [3:0]    blk;
  logic          in_phase;
  logic          is_write;
  block_t        pattern;
  block_t        read_block;

  // ==================================================
  // decode of the current state code
  // ==================================================
  always_comb begin
    blk      = state[11:8];
    is_write = (state[7:0] == TEST_WRITE[7:0]);
    in_phase = (state[15:12] == 4'h0) &&
               (state[7:0] == TEST_WRITE[7:0] || state[7:0] == TEST_READ[7:0]);
    pattern  = block_pattern(block_addr_t'(blk));
  end

  always_comb begin
    request = '0;
    if (in_phase && step == STEP_ISSUE) begin
      request.write = is_write;
      request.read  = !is_write;
      request.addr  = block_addr_t'(blk);
      request.data  = pattern;  // ignored on reads.
    end
  end

  assign test_state = state;

  // ==================================================
  // sequencing
  // ==================================================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= TEST_START;
      step  <= STEP_ISSUE;
    end else if (state == TEST_START) begin
      state <= TEST_WRITE;  // block 0.
      step  <= STEP_ISSUE;
    end else if (in_phase) begin
      case (step)
        STEP_ISSUE: begin
          if (response.busy) begin
            step <= STEP_WAIT;
          end
        end
        STEP_WAIT: begin
          if (!response.busy) begin
            if (response.fault) begin
              state <= LINK_FAULT;
            end else if (is_write) begin
              step <= STEP_GAP;
            end else begin
              step <= STEP_CHECK;
            end
          end
        end
        STEP_CHECK: begin
          if (read_block != pattern) begin
            state <= READ_ERROR;
          end else begin
            step <= STEP_GAP;
          end
        end
        default: begin
          step <= STEP_ISSUE;
          if (blk != 4'(TEST_BLOCKS - 1)) begin
            state <= state + 16'h0100;  // next block.
          end else if (is_write) begin
            state <= TEST_READ;
          end else begin
            state <= TEST_END;
          end
        end
      endcase
    end
  end

  // capture the block as busy falls.
  always_ff @(posedge clock) begin
    if (in_phase && step == STEP_WAIT && !response.busy) begin
      read_block <= response.data;
    end
  end

endmodule

// ==== source/sd_selftest_top.sv ====
`timescale 1ns/1ps

module sd_selftest_top import sd_test_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          miso,
  output logic          sclk,
  output logic          mosi,
  output logic          cs_n,
  output tester_state_t test_state
);

  sd_request_t  request;
  sd_response_t response;

  // pattern source and checker.
  sd_block_tester u_tester (
    .clock      (clock),
    .reset      (reset),
    .response   (response),
    .request    (request),
    .test_state (test_state)
  );

  // single-block transfers over spi.
  sd_block_controller u_controller (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .miso     (miso),
    .response (response),
    .sclk     (sclk),
    .mosi     (mosi),
    .cs_n     (cs_n)
  );

endmodule

// ==== test/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model import sd_test_pkg::*; (
  input  logic        sclk,
  input  logic        mosi,
  input  logic        cs_n,
  input  logic        clear,
  input  logic        corrupt_en,
  input  block_addr_t corrupt_blk,
  input  logic        reject_en,
  input  block_addr_t reject_blk,
  output logic        miso
);

  localparam logic [1:0] ST_CMD      = 2'd0;
  localparam logic [1:0] ST_WR_TOKEN = 2'd1;
  localparam logic [1:0] ST_WR_DATA  = 2'd2;
  localparam logic [1:0] ST_OTHER    = 2'd3;

  block_t      mem [TEST_BLOCKS];
  logic [5:0]  log_index [$];
  block_addr_t log_arg [$];
  logic [7:0]  out_q [$];
  logic [7:0]  out_reg = 8'hFF;
  logic [7:0]  rx_reg;
  logic [47:0] frame;
  logic [1:0]  state;
  logic        load_next;
  block_addr_t cur_addr;
  logic [31:0] rand_state = 32'd17;
  int          bit_count;
  int          frame_count;
  int          data_count;

  assign miso = out_reg[7];

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // queue 1 to max_count fill bytes.
  task automatic push_delay(input logic [7:0] fill, input int max_count);
    int n;
    rand_state = xorshift(rand_state);
    n = 1 + int'(rand_state % 32'(max_count));
    repeat (n) out_q.push_back(fill);
  endtask

  task automatic reset_link();
    out_q.delete();
    out_reg     = 8'hFF;
    bit_count   = 0;
    frame_count = 0;
    load_next   = 1'b0;
    state       = ST_CMD;
  endtask

  task automatic handle_byte(input logic [7:0] b);
    logic [7:0] d;
    case (state)
      ST_CMD: begin
        if (frame_count > 0 || b[7:6] == 2'b01) begin
          frame = {frame[39:0], b};
          frame_count++;
          if (frame_count == 6) begin
            frame_count = 0;
            cur_addr    = frame[39:8];
            log_index.push_back(frame[45:40]);
            log_arg.push_back(cur_addr);
            push_delay(8'hFF, 7);  // r1 delay.
            out_q.push_back(8'h00);
            if (frame[45:40] == CMD_WRITE_BLOCK) begin
              state = ST_WR_TOKEN;
            end else begin
              state = ST_OTHER;
              push_delay(8'hFF, 16);  // token delay.
              out_q.push_back(TOKEN_START);
              for (int k = 0; k < 512; k++) begin
                d = mem[cur_addr[1:0]][8*k +: 8];
                if (corrupt_en && cur_addr == corrupt_blk && k == 100) d = ~d;
                out_q.push_back(d);
              end
              out_q.push_back(8'hFF);
              out_q.push_back(8'hFF);
            end
          end
        end
      end
      ST_WR_TOKEN: begin
        if (b == TOKEN_START) begin
          state      = ST_WR_DATA;
          data_count = 0;
        end
      end
      ST_WR_DATA: begin
        if (data_count < 512) mem[cur_addr[1:0]][8*data_count +: 8] = b;
        data_count++;
        if (data_count == 514) begin  // data plus two crc bytes.
          state = ST_OTHER;
          if (reject_en && cur_addr == reject_blk) begin
            out_q.push_back(8'hEB);  // crc error response.
          end else begin
            out_q.push_back(8'hE5);
            push_delay(8'h00, 64);  // programming busy.
          end
        end
      end
      default: ;
    endcase
  endtask

  // mode 0, sample on rising sclk, shift on falling.
  always @(posedge sclk or negedge sclk or posedge cs_n or posedge clear) begin
    if (clear) begin
      foreach (mem[i]) mem[i] = '0;
      log_index.delete();
      log_arg.delete();
      reset_link();
    end else if (cs_n) begin
      reset_link();
    end else if (sclk) begin
      rx_reg = {rx_reg[6:0], mosi};
      bit_count++;
      if (bit_count == 8) begin
        bit_count = 0;
        load_next = 1'b1;
        handle_byte(rx_reg);
      end
    end else if (load_next) begin
      load_next = 1'b0;
      out_reg   = (out_q.size() > 0) ? out_q.pop_front() : 8'hFF;
    end else begin
      out_reg = {out_reg[6:0], 1'b1};
    end
  end

endmodule

// ==== test/sd_block_controller_asserts.sv ====
`timescale 1ns/1ps

module sd_block_controller_asserts import sd_test_pkg::*; (
  input logic        clock,
  input logic        reset,
  input sd_request_t request,
  input logic        busy,
  input logic [3:0]  phase,
  input logic        shift_sclk,
  input logic        cs_n
);

  int failures = 0;  // failed assertion count.

  // a new request comes at least two cycles after busy falls.
  a_request_gap: assert property (@(posedge clock) disable iff (reset)
    ((request.read || request.write) && !busy) |-> (!$past(busy) && !$past(busy, 2)))
    else begin
      failures++;
      $error("request issued within two cycles of busy falling");
    end

  // cs_n only moves while the shifter clock rests low.
  a_sclk_idle: assert property (@(posedge clock) disable iff (reset)
    (cs_n != $past(cs_n)) |-> (!shift_sclk && !$past(shift_sclk)))
    else begin
      failures++;
      $error("cs_n changed while the shifter clock was high");
    end

  a_busy_rise: assert property (@(posedge clock) disable iff (reset)
    (phase == CTRL_IDLE && (request.read || request.write)) |=> busy)
    else begin
      failures++;
      $error("busy did not rise after an accepted request");
    end

endmodule

// ==== test/sd_selftest_tb.sv ====
`timescale 1ns/1ps

module sd_selftest_tb import sd_test_pkg::*; ();

  localparam int CYCLE_LIMIT = 600000;  // three runs with margin.

  logic          clock = 1'b0;
  logic          reset;
  logic          miso;
  logic          sclk;
  logic          mosi;
  logic          cs_n;
  tester_state_t test_state;
  logic          clear;
  logic          corrupt_en;
  logic          reject_en;
  block_addr_t   corrupt_blk;
  block_addr_t   reject_blk;
  int            cycles = 0;

  sd_selftest_top DUT (
    .clock(clock), .reset(reset), .miso(miso),
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .test_state(test_state)
  );

  sd_card_model card (
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .clear(clear),
    .corrupt_en(corrupt_en), .corrupt_blk(corrupt_blk),
    .reject_en(reject_en), .reject_blk(reject_blk), .miso(miso)
  );

  bind sd_block_controller sd_block_controller_asserts u_asserts (
    .clock(clock), .reset(reset), .request(request), .busy(response.busy),
    .phase(phase), .shift_sclk(shift_sclk), .cs_n(cs_n)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, no final tester state was reached", cycles);
      $display("Verification failed");
      $fatal(1);
    end
  end

  // ==================================================
  // checks
  // ==================================================
  task automatic fail_plain(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_state(input string name, input tester_state_t exp,
                             input tester_state_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_block(input string name, input block_t exp, input block_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_addr(input string name, input block_addr_t exp, input block_addr_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // bytes count up from the low byte of a*16, each xor A5.
  function automatic block_t expected_block(input block_addr_t a);
    block_t     blk;
    logic [7:0] count;
    count = {a[3:0], 4'h0};
    for (int k = 0; k < 512; k++) begin
      blk[8*k +: 8] = count ^ 8'hA5;
      count = count + 8'd1;
    end
    return blk;
  endfunction

  task automatic check_log_entry(input string name, input int i, input int idx, input int arg);
    check_addr(name, block_addr_t'(idx), block_addr_t'(card.log_index[i]));
    check_addr(name, block_addr_t'(arg), card.log_arg[i]);
  endtask

  task automatic wait_final();
    while (test_state != TEST_END && test_state != READ_ERROR && test_state != LINK_FAULT)
      @(negedge clock);
  endtask

  // ==================================================
  // directed tests
  // ==================================================
  task automatic reset_state(input string name);
    @(negedge clock);
    reset = 1'b1;
    clear = 1'b1;
    repeat (3) @(negedge clock);
    check_state(name, TEST_START, test_state);
    if (cs_n !== 1'b1 || sclk !== 1'b0 || mosi !== 1'b1) begin
      fail_plain("cs_n, sclk or mosi wrong during reset");
    end
    reset = 1'b0;
    clear = 1'b0;
  endtask

  task automatic full_pass();
    wait_final();
    check_state("full_pass", TEST_END, test_state);
    if (card.log_index.size() != 8) begin
      fail_plain("full_pass: card saw the wrong number of commands");
    end
    for (int i = 0; i < 4; i++) begin
      check_log_entry("full_pass", i, 24, i);
      check_log_entry("full_pass", i + 4, 17, i);
    end
  endtask

  task automatic write_content();
    for (int a = 0; a < TEST_BLOCKS; a++)
      check_block("write_content", expected_block(block_addr_t'(a)), card.mem[a]);
  endtask

  task automatic read_corrupt();
    @(negedge clock);
    corrupt_en  = 1'b1;
    corrupt_blk = 32'd2;
    reset_state("read_corrupt");
    wait_final();
    check_state("read_corrupt", READ_ERROR, test_state);
    if (card.log_index.size() != 7) begin
      fail_plain("read_corrupt: wrong number of commands around the bad read");
    end
    check_log_entry("read_corrupt", 6, 17, 2);
    corrupt_en = 1'b0;
  endtask

  task automatic write_reject();
    @(negedge clock);
    reject_en  = 1'b1;
    reject_blk = 32'd1;
    reset_state("write_reject");
    wait_final();
    check_state("write_reject", LINK_FAULT, test_state);
    if (card.log_index.size() != 2) begin
      fail_plain("write_reject: wrong number of commands around the rejected write");
    end
    check_log_entry("write_reject", 1, 24, 1);
    reject_en = 1'b0;
  endtask

  initial begin
    reset       = 1'b1;
    clear       = 1'b0;
    corrupt_en  = 1'b0;
    reject_en   = 1'b0;
    corrupt_blk = '0;
    reject_blk  = '0;
    reset_state("reset_state");
    full_pass();
    write_content();
    read_corrupt();
    write_reject();
    if (DUT.u_controller.u_asserts.failures == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("assertions on the block controller failed");
      $display("Verification failed");
      $fatal(1);
    end
  end

endmodule

// ==== files.f ====
source/sd_test_pkg.sv
source/spi_byte_shifter.sv
source/sd_block_controller.sv
source/sd_block_tester.sv
source/sd_selftest_top.sv
test/sd_card_model.sv
test/sd_block_controller_asserts.sv
test/sd_selftest_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sd_selftest_tb
FILELIST = files.f
OBJ_DIR  = obj_dir

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
